//--- logic/exec_cfg_pkg.sv
package exec_cfg_pkg;

    // operand and result width
    localparam int xlen = 64;
    // W operations work on the low half
    localparam int half_xlen = 32;
    // shift amount and iteration counter width
    localparam int log_xlen = $clog2(xlen);

    // destination register number
    localparam int reg_addr_bits = 5;

    // result queue entries
    localparam int queue_depth = 2;
    localparam int queue_ptr_bits = $clog2(queue_depth);
    // count runs 0..queue_depth inclusive
    localparam int queue_count_bits = $clog2(queue_depth + 1);

endpackage

//--- logic/exec_op_pkg.sv
package exec_op_pkg;

    localparam int op_bits = 5;

    // single-cycle ops first, iterative ops at the top
    typedef enum logic [op_bits-1:0] {
        op_add  = 5'd0,
        op_sub  = 5'd1,
        op_xor  = 5'd2,
        op_or   = 5'd3,
        op_and  = 5'd4,
        op_slt  = 5'd5,
        op_sltu = 5'd6,
        op_sll  = 5'd7,
        op_srl  = 5'd8,
        op_sra  = 5'd9,
        // handled by the multiplier / divider
        op_mul  = 5'd10,
        op_div  = 5'd11,
        op_divs = 5'd12,
        op_rem  = 5'd13,
        op_rems = 5'd14
    } alu_op_t;

    // codes at or above this leave the alu
    localparam alu_op_t first_multi_op = op_mul;

endpackage

//--- logic/int_alu.sv
`timescale 1ns/1ps

module int_alu (
    input  exec_op_pkg::alu_op_t          op,
    input  logic                          word,
    input  logic [exec_cfg_pkg::xlen-1:0] src1,
    input  logic [exec_cfg_pkg::xlen-1:0] src2,
    output logic [exec_cfg_pkg::xlen-1:0] result
);
    import exec_cfg_pkg::*;
    import exec_op_pkg::*;

    logic [log_xlen-1:0] shamt;
    logic [xlen-1:0]     srl_src;
    logic [xlen-1:0]     sra_src;
    logic [xlen-1:0]     raw;

    // word shifts only look at 5 bits of the amount
    assign shamt = word ? {1'b0, src2[log_xlen-2:0]} : src2[log_xlen-1:0];

    // srlw shifts in zeros from bit 31
    assign srl_src = word ? {{half_xlen{1'b0}}, src1[half_xlen-1:0]} : src1;
    // sraw shifts in copies of bit 31
    assign sra_src = word ? {{half_xlen{src1[half_xlen-1]}}, src1[half_xlen-1:0]} : src1;

    always_comb begin
        case (op)
            op_add:  raw = src1 + src2;
            op_sub:  raw = src1 - src2;
            op_xor:  raw = src1 ^ src2;
            op_or:   raw = src1 | src2;
            op_and:  raw = src1 & src2;
            // compares give 0 or 1
            op_slt:  raw = {{(xlen-1){1'b0}}, ($signed(src1) < $signed(src2))};
            op_sltu: raw = {{(xlen-1){1'b0}}, (src1 < src2)};
            op_sll:  raw = src1 << shamt;
            op_srl:  raw = srl_src >> shamt;
            op_sra:  raw = $signed(sra_src) >>> shamt;
            // mul/div come from the iterative units
            default: raw = '0;
        endcase
    end

    // W result: low word, sign extended
    assign result = word ? {{half_xlen{raw[half_xlen-1]}}, raw[half_xlen-1:0]} : raw;

endmodule

//--- logic/seq_multiplier.sv
`timescale 1ns/1ps

module seq_multiplier (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          start,
    input  logic [exec_cfg_pkg::xlen-1:0] src1,
    input  logic [exec_cfg_pkg::xlen-1:0] src2,
    output logic                          busy,
    output logic                          done,
    output logic [exec_cfg_pkg::xlen-1:0] product
);
    import exec_cfg_pkg::*;

    logic [xlen-1:0]     mcand;
    logic [xlen-1:0]     mplier;
    logic [xlen-1:0]     acc;
    logic [log_xlen-1:0] step;
    logic                last_step;

    // one multiplier bit per cycle, xlen cycles
    assign last_step = (step == log_xlen'(xlen - 1));

    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
            step <= '0;
        end else begin
            // done pulses the cycle after the last add
            done <= busy && last_step;
            if (start) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                step <= step + 1'b1;
                if (last_step) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // shift-add, low xlen bits only
    // low half is sign-agnostic so no signed mode
    always_ff @(posedge clock) begin
        if (start) begin
            mcand  <= src1;
            mplier <= src2;
            acc    <= '0;
        end else if (busy) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign product = acc;

endmodule

//--- logic/seq_divider.sv
`timescale 1ns/1ps

module seq_divider (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          start,
    input  logic                          signed_mode,
    input  logic [exec_cfg_pkg::xlen-1:0] dividend,
    input  logic [exec_cfg_pkg::xlen-1:0] divisor,
    output logic                          busy,
    output logic                          done,
    output logic [exec_cfg_pkg::xlen-1:0] quotient,
    output logic [exec_cfg_pkg::xlen-1:0] remainder
);
    import exec_cfg_pkg::*;

    logic [xlen-1:0]     quo;
    logic [xlen-1:0]     rem;
    logic [xlen-1:0]     dvsr;
    logic                neg_quo;
    logic                neg_rem;
    logic [log_xlen-1:0] step;
    logic                last_step;
    logic                dividend_neg;
    logic                divisor_neg;
    logic [xlen-1:0]     dividend_mag;
    logic [xlen-1:0]     divisor_mag;
    logic                div_by_zero;
    logic                overflow;
    logic [xlen:0]       partial;
    logic [xlen:0]       trial;

    // work on magnitudes, fix signs at the output
    assign dividend_neg = signed_mode && dividend[xlen-1];
    assign divisor_neg  = signed_mode && divisor[xlen-1];
    assign dividend_mag = dividend_neg ? -dividend : dividend;
    assign divisor_mag  = divisor_neg ? -divisor : divisor;

    // RISC-V corner cases, no iterations
    assign div_by_zero = (divisor == '0);
    assign overflow    = signed_mode && (dividend == {1'b1, {(xlen-1){1'b0}}}) && (&divisor);

    // bring down next dividend bit, trial subtract
    assign partial   = {rem, quo[xlen-1]};
    assign trial     = partial - {1'b0, dvsr};
    assign last_step = (step == log_xlen'(xlen - 1));

    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
            step <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                step <= '0;
                if (div_by_zero || overflow) begin
                    done <= 1'b1;
                end else begin
                    busy <= 1'b1;
                end
            end else if (busy) begin
                step <= step + 1'b1;
                if (last_step) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            if (div_by_zero) begin
                // quotient all ones, remainder is the dividend
                quo     <= '1;
                rem     <= dividend;
                neg_quo <= 1'b0;
                neg_rem <= 1'b0;
            end else if (overflow) begin
                quo     <= dividend;
                rem     <= '0;
                neg_quo <= 1'b0;
                neg_rem <= 1'b0;
            end else begin
                quo     <= dividend_mag;
                rem     <= '0;
                dvsr    <= divisor_mag;
                neg_quo <= dividend_neg ^ divisor_neg;
                // remainder takes the dividend's sign
                neg_rem <= dividend_neg;
            end
        end else if (busy) begin
            // borrow out means the subtract failed, restore
            if (!trial[xlen]) begin
                rem <= trial[xlen-1:0];
                quo <= {quo[xlen-2:0], 1'b1};
            end else begin
                rem <= partial[xlen-1:0];
                quo <= {quo[xlen-2:0], 1'b0};
            end
        end
    end

    assign quotient  = neg_quo ? -quo : quo;
    assign remainder = neg_rem ? -rem : rem;

endmodule

//--- logic/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic                                   in_valid,
    output logic                                   in_ready,
    input  exec_op_pkg::alu_op_t                   in_op,
    input  logic                                   in_word,
    input  logic [exec_cfg_pkg::xlen-1:0]          in_src1,
    input  logic [exec_cfg_pkg::xlen-1:0]          in_src2,
    input  logic [exec_cfg_pkg::reg_addr_bits-1:0] in_rd,
    output logic                                   push_valid,
    input  logic                                   push_ready,
    output logic [exec_cfg_pkg::xlen-1:0]          push_data,
    output logic [exec_cfg_pkg::reg_addr_bits-1:0] push_rd
);
    import exec_cfg_pkg::*;
    import exec_op_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_running,
        st_holding
    } state_t;

    state_t                   state;
    logic                     is_multi;
    logic                     is_mul;
    logic                     is_rem;
    logic                     is_signed_div;
    logic                     idle;
    logic                     accept;
    logic [xlen-1:0]          alu_result;
    logic                     mul_start;
    logic                     mul_busy;
    logic                     mul_done;
    logic [xlen-1:0]          mul_product;
    logic                     div_start;
    logic                     div_busy;
    logic                     div_done;
    logic [xlen-1:0]          div_src1;
    logic [xlen-1:0]          div_src2;
    logic [xlen-1:0]          div_quotient;
    logic [xlen-1:0]          div_remainder;
    logic                     word_q;
    logic                     kind_mul_q;
    logic                     kind_rem_q;
    logic [reg_addr_bits-1:0] rd_q;
    logic                     unit_done;
    logic [xlen-1:0]          unit_raw;
    logic [xlen-1:0]          unit_result;
    logic [xlen-1:0]          hold_data;

    // low word, sign or zero extended
    function automatic logic [xlen-1:0] extend_word(input logic [xlen-1:0] value,
                                                    input logic sign);
        extend_word = {{half_xlen{sign && value[half_xlen-1]}}, value[half_xlen-1:0]};
    endfunction

    // opcode classes
    assign is_multi      = (in_op >= first_multi_op);
    assign is_mul        = (in_op == op_mul);
    assign is_rem        = (in_op == op_rem) || (in_op == op_rems);
    assign is_signed_div = (in_op == op_divs) || (in_op == op_rems);

    // no new issue until the previous iterative result is pushed
    assign idle     = (state == st_idle) && !mul_busy && !div_busy;
    assign in_ready = idle && push_ready;
    assign accept   = in_valid && in_ready;

    assign mul_start = accept && is_mul;
    assign div_start = accept && is_multi && !is_mul;

    // W divide: 32-bit operands widened, 64-bit divide gives the W result
    assign div_src1 = in_word ? extend_word(in_src1, is_signed_div) : in_src1;
    assign div_src2 = in_word ? extend_word(in_src2, is_signed_div) : in_src2;

    int_alu alu_inst (
        .op     (in_op),
        .word   (in_word),
        .src1   (in_src1),
        .src2   (in_src2),
        .result (alu_result)
    );

    seq_multiplier mul_inst (
        .clock   (clock),
        .reset   (reset),
        .start   (mul_start),
        .src1    (in_src1),
        .src2    (in_src2),
        .busy    (mul_busy),
        .done    (mul_done),
        .product (mul_product)
    );

    seq_divider div_inst (
        .clock       (clock),
        .reset       (reset),
        .start       (div_start),
        .signed_mode (is_signed_div),
        .dividend    (div_src1),
        .divisor     (div_src2),
        .busy        (div_busy),
        .done        (div_done),
        .quotient    (div_quotient),
        .remainder   (div_remainder)
    );

    // only one unit runs at a time
    assign unit_done   = mul_done || div_done;
    assign unit_raw    = kind_mul_q ? mul_product : (kind_rem_q ? div_remainder : div_quotient);
    assign unit_result = word_q ? extend_word(unit_raw, 1'b1) : unit_raw;

    // push source follows the state
    always_comb begin
        case (state)
            st_running: begin
                push_valid = unit_done;
                push_data  = unit_result;
                push_rd    = rd_q;
            end
            st_holding: begin
                push_valid = 1'b1;
                push_data  = hold_data;
                push_rd    = rd_q;
            end
            default: begin
                // single-cycle ops go straight through
                push_valid = in_valid && !is_multi && idle;
                push_data  = alu_result;
                push_rd    = in_rd;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (accept && is_multi) begin
                        state <= st_running;
                    end
                end
                st_running: begin
                    if (unit_done) begin
                        state <= push_ready ? st_idle : st_holding;
                    end
                end
                st_holding: begin
                    if (push_ready) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // latched op info and held result
    always_ff @(posedge clock) begin
        if (accept && is_multi) begin
            word_q     <= in_word;
            kind_mul_q <= is_mul;
            kind_rem_q <= is_rem;
            rd_q       <= in_rd;
        end
        // queue full at done
        if ((state == st_running) && unit_done && !push_ready) begin
            hold_data <= unit_result;
        end
    end

endmodule

//--- logic/result_queue.sv
`timescale 1ns/1ps

module result_queue (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic                                   push_valid,
    output logic                                   push_ready,
    input  logic [exec_cfg_pkg::xlen-1:0]          push_data,
    input  logic [exec_cfg_pkg::reg_addr_bits-1:0] push_rd,
    output logic                                   pop_valid,
    input  logic                                   pop_ready,
    output logic [exec_cfg_pkg::xlen-1:0]          pop_data,
    output logic [exec_cfg_pkg::reg_addr_bits-1:0] pop_rd
);
    import exec_cfg_pkg::*;

    logic [xlen-1:0]             data_mem [queue_depth];
    logic [reg_addr_bits-1:0]    rd_mem [queue_depth];
    logic [queue_ptr_bits-1:0]   wr_ptr;
    logic [queue_ptr_bits-1:0]   rd_ptr;
    logic [queue_count_bits-1:0] count;
    logic                        do_push;
    logic                        do_pop;

    function automatic logic [queue_ptr_bits-1:0] next_ptr(input logic [queue_ptr_bits-1:0] ptr);
        next_ptr = (ptr == queue_ptr_bits'(queue_depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign pop_valid = (count != '0);
    // full queue still takes a push when a pop happens on the same edge
    assign push_ready = (count != queue_count_bits'(queue_depth)) || pop_ready;

    assign do_push = push_valid && push_ready;
    assign do_pop  = pop_valid && pop_ready;

    assign pop_data = data_mem[rd_ptr];
    assign pop_rd   = rd_mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // push and pop together leave count unchanged
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (do_push) begin
            data_mem[wr_ptr] <= push_data;
            rd_mem[wr_ptr]   <= push_rd;
        end
    end

endmodule

//--- logic/exec_top.sv
`timescale 1ns/1ps

module exec_top (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic                                   in_valid,
    output logic                                   in_ready,
    input  exec_op_pkg::alu_op_t                   in_op,
    input  logic                                   in_word,
    input  logic [exec_cfg_pkg::xlen-1:0]          in_src1,
    input  logic [exec_cfg_pkg::xlen-1:0]          in_src2,
    input  logic [exec_cfg_pkg::reg_addr_bits-1:0] in_rd,
    output logic                                   res_valid,
    input  logic                                   res_ready,
    output logic [exec_cfg_pkg::xlen-1:0]          res_data,
    output logic [exec_cfg_pkg::reg_addr_bits-1:0] res_rd
);
    import exec_cfg_pkg::*;

    // execute unit to result queue
    logic                     push_valid;
    logic                     push_ready;
    logic [xlen-1:0]          push_data;
    logic [reg_addr_bits-1:0] push_rd;

    exec_unit exec_unit_inst (
        .clock      (clock),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_op      (in_op),
        .in_word    (in_word),
        .in_src1    (in_src1),
        .in_src2    (in_src2),
        .in_rd      (in_rd),
        .push_valid (push_valid),
        .push_ready (push_ready),
        .push_data  (push_data),
        .push_rd    (push_rd)
    );

    // queue output is the result port
    result_queue result_queue_inst (
        .clock      (clock),
        .reset      (reset),
        .push_valid (push_valid),
        .push_ready (push_ready),
        .push_data  (push_data),
        .push_rd    (push_rd),
        .pop_valid  (res_valid),
        .pop_ready  (res_ready),
        .pop_data   (res_data),
        .pop_rd     (res_rd)
    );

endmodule

//--- tb/exec_top_tb.sv
`timescale 1ns/1ps

module exec_top_tb;
    import exec_cfg_pkg::*;
    import exec_op_pkg::*;

    // handshake wait limit in cycles
    localparam int max_wait = 200;
    // in_ready low this long counts as blocked
    localparam int stall_window = 150;
    localparam int max_ops = 64;

    logic                     clock;
    logic                     reset;
    logic                     in_valid;
    logic                     in_ready;
    alu_op_t                  in_op;
    logic                     in_word;
    logic [xlen-1:0]          in_src1;
    logic [xlen-1:0]          in_src2;
    logic [reg_addr_bits-1:0] in_rd;
    logic                     res_valid;
    logic                     res_ready;
    logic [xlen-1:0]          res_data;
    logic [reg_addr_bits-1:0] res_rd;

    // trace contents, one entry per line
    logic [op_bits-1:0]       trace_op [max_ops];
    logic                     trace_word [max_ops];
    logic [xlen-1:0]          trace_src1 [max_ops];
    logic [xlen-1:0]          trace_src2 [max_ops];
    logic [reg_addr_bits-1:0] trace_rd [max_ops];
    logic [xlen-1:0]          trace_result [max_ops];
    int                       trace_len;

    // expected results in issue order
    logic [xlen-1:0]          expected_data_q [$];
    logic [reg_addr_bits-1:0] expected_rd_q [$];
    logic [xlen-1:0]          exp_data;
    logic [reg_addr_bits-1:0] exp_rd;

    logic                     hold_results;
    logic                     ready_level;
    int                       stretch_left;

    exec_top exec_top_inst (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_op     (in_op),
        .in_word   (in_word),
        .in_src1   (in_src1),
        .in_src2   (in_src2),
        .in_rd     (in_rd),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_data  (res_data),
        .res_rd    (res_rd)
    );

    initial clock = 1'b0;
    always #4 clock = ~clock;

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [xlen-1:0] actual,
                               input logic [xlen-1:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, actual, expected);
            fail_now("value mismatch");
        end
    endtask

    task automatic load_trace();
        int              fd;
        int              got;
        int              fields;
        string           line;
        logic [31:0]     op_val;
        logic [31:0]     word_val;
        logic [31:0]     rd_val;
        logic [xlen-1:0] s1;
        logic [xlen-1:0] s2;
        logic [xlen-1:0] exp_val;
        fd = $fopen("tb/exec_trace.txt", "r");
        if (fd == 0) begin
            fail_now("could not open the trace file tb/exec_trace.txt");
        end else begin
            trace_len = 0;
            while (!$feof(fd) && trace_len < max_ops) begin
                line = "";
                got = $fgets(line, fd);
                // skip blank and '#' lines
                if (got > 0 && line.len() > 0 && line[0] != 8'h23) begin
                    fields = $sscanf(line, "%h %h %h %h %h %h",
                                     op_val, word_val, s1, s2, rd_val, exp_val);
                    if (fields == 6) begin
                        trace_op[trace_len]     = op_val[op_bits-1:0];
                        trace_word[trace_len]   = word_val[0];
                        trace_src1[trace_len]   = s1;
                        trace_src2[trace_len]   = s2;
                        trace_rd[trace_len]     = rd_val[reg_addr_bits-1:0];
                        trace_result[trace_len] = exp_val;
                        trace_len++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // drive one op and wait up to limit edges for the transfer
    task automatic offer_op(input int idx, input int limit, output bit taken);
        in_op    = alu_op_t'(trace_op[idx]);
        in_word  = trace_word[idx];
        in_src1  = trace_src1[idx];
        in_src2  = trace_src2[idx];
        in_rd    = trace_rd[idx];
        in_valid = 1'b1;
        taken    = 1'b0;
        for (int n = 0; n < limit && !taken; n++) begin
            @(posedge clock);
            if (in_ready) begin
                taken = 1'b1;
                expected_data_q.push_back(trace_result[idx]);
                expected_rd_q.push_back(trace_rd[idx]);
            end
        end
        #1;
        // still offered when not taken
        if (taken) begin
            in_valid = 1'b0;
        end
    endtask

    task automatic issue_op(input int idx);
        bit taken;
        offer_op(idx, max_wait, taken);
        if (!taken) begin
            fail_now($sformatf("timeout: in_ready never rose for trace entry %0d", idx));
        end
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (expected_data_q.size() != 0 && n < max_wait) begin
            @(posedge clock);
            #1;
            n++;
        end
        if (expected_data_q.size() != 0) begin
            fail_now("timeout: res_valid stalled with results still outstanding");
        end
    endtask

    // result port monitor
    always @(posedge clock) begin
        if (!reset && res_valid && res_ready) begin
            if (expected_data_q.size() == 0) begin
                fail_now($sformatf("result for rd %0d arrived with none outstanding", res_rd));
            end else begin
                exp_data = expected_data_q.pop_front();
                exp_rd   = expected_rd_q.pop_front();
                check_value("res_data", res_data, exp_data);
                check_value("res_rd", xlen'(res_rd), xlen'(exp_rd));
            end
        end
    end

    // consumer back-pressure in random stretches
    initial begin
        void'($urandom(19874));
        ready_level  = 1'b1;
        stretch_left = 0;
        forever begin
            @(posedge clock);
            #1;
            if (stretch_left == 0) begin
                ready_level  = ($urandom % 3) != 0;
                stretch_left = 1 + ($urandom % 6);
            end
            stretch_left--;
            res_ready = hold_results ? 1'b0 : ready_level;
        end
    end

    initial begin
        int  accepted;
        int  idx;
        bit  taken;
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_op        = op_add;
        in_word      = 1'b0;
        in_src1      = '0;
        in_src2      = '0;
        in_rd        = '0;
        res_ready    = 1'b1;
        hold_results = 1'b0;
        load_trace();
        repeat (10) @(posedge clock);
        #1;
        reset = 1'b0;
        @(posedge clock);
        #1;
        // idle state right after reset
        check_value("res_valid", xlen'(res_valid), 0);
        check_value("in_ready", xlen'(in_ready), 1);

        // whole trace back to back
        for (int i = 0; i < trace_len; i++) begin
            issue_op(i);
        end
        wait_drained();

        // consumer stalled so count accepted ops until in_ready stays low
        hold_results = 1'b1;
        repeat (2) @(posedge clock);
        #1;
        accepted = 0;
        idx      = 0;
        taken    = 1'b1;
        while (taken && idx < trace_len) begin
            offer_op(idx, stall_window, taken);
            if (taken) begin
                accepted++;
                idx++;
            end
        end
        check_value("in_ready_blocked", xlen'(taken), 0);
        check_value("accepted_at_most_three", xlen'(accepted <= 3), 1);
        // drain again and let the pending op through
        hold_results = 1'b0;
        issue_op(idx);
        wait_drained();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- tb/exec_trace.txt
# op word src1 src2 rd expected, all hex
# op: 0 add 1 sub 2 xor 3 or 4 and 5 slt 6 sltu 7 sll 8 srl 9 sra a mul b div c divs d rem e rems
0 0 0000000000000005 0000000000000007 01 000000000000000c
1 0 0000000000000003 0000000000000005 02 fffffffffffffffe
2 0 00ff00ff00ff00ff 0f0f0f0f0f0f0f0f 03 0ff00ff00ff00ff0
3 0 00ff00ff00ff00ff 0f0f0f0f0f0f0f0f 04 0fff0fff0fff0fff
4 0 00ff00ff00ff00ff 0f0f0f0f0f0f0f0f 05 000f000f000f000f
5 0 ffffffffffffffff 0000000000000001 06 0000000000000001
6 0 ffffffffffffffff 0000000000000001 07 0000000000000000
7 0 0000000000000001 0000000000000043 08 0000000000000008
7 1 0000000000000001 000000000000003f 09 ffffffff80000000
8 0 8000000000000000 0000000000000004 0a 0800000000000000
8 1 ffffffff80000000 0000000000000004 0b 0000000008000000
9 0 8000000000000000 0000000000000004 0c f800000000000000
9 1 0000000080000000 0000000000000024 0d fffffffff8000000
0 1 000000007fffffff 0000000000000001 0e ffffffff80000000
a 0 fffffffffffffffd 0000000000000007 0f ffffffffffffffeb
a 1 0000000000010001 0000000000008000 10 ffffffff80008000
a 0 00000000ffffffff 00000000ffffffff 11 fffffffe00000001
b 0 0000000000000064 0000000000000007 12 000000000000000e
c 0 ffffffffffffff9c 0000000000000007 13 fffffffffffffff2
e 0 ffffffffffffff9c 0000000000000007 14 fffffffffffffffe
d 0 0000000000000064 0000000000000007 15 0000000000000002
c 0 0000000000000011 0000000000000000 16 ffffffffffffffff
e 0 fffffffffffffff0 0000000000000000 17 fffffffffffffff0
c 0 8000000000000000 ffffffffffffffff 18 8000000000000000
e 0 8000000000000000 ffffffffffffffff 19 0000000000000000
c 1 00000000fffffff9 0000000000000002 1a fffffffffffffffd

//--- verilog.f
logic/exec_cfg_pkg.sv
logic/exec_op_pkg.sv
logic/int_alu.sv
logic/seq_multiplier.sv
logic/seq_divider.sv
logic/exec_unit.sv
logic/result_queue.sv
logic/exec_top.sv
tb/exec_top_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := exec_top_tb
FILE_LIST  := verilog.f
LINT_FLAGS := --lint-only --timing -Wall
SIM_FLAGS  := --binary --timing -Wno-fatal
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_TEXT  := ALL TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
